/* files.f */
verilog/flash_pkg.sv
verilog/flash_bus_if.sv
verilog/flash_controller.sv
verilog/flash_read_buffer.sv
verilog/flash_read_top.sv
bench/flash_model.sv
bench/flash_pins_chk.sv
bench/flash_read_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= flash_read_tb
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= --lint-only
SIM_FLAGS  ?= --binary -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* bench/flash_read_tb.sv */
`timescale 1ns/1ps

module flash_read_tb
    import flash_pkg::*;
();

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 10;
    localparam int WAIT_CYCLES   = 3;
    localparam int LINES         = 4;
    localparam int MISS_STALLS   = 4 * WAIT_CYCLES + 1;
    localparam int TIMEOUT       = 20 * MISS_STALLS;
    localparam int RANDOM_READS  = 200;
    localparam int RANDOM_SPAN   = 16;
    localparam int RANDOM_SEED   = 74840;
    localparam int FIRST_ADDR    = 5;
    localparam int CONFLICT_ADDR = 6;

    logic        clk;
    logic        rst;
    word_addr_t  bus_address;
    logic        bus_read;
    word_t       bus_read_data;
    logic        bus_stall;
    flash_addr_t flash_address;
    logic        flash_ce_n;
    logic        flash_we_n;
    logic        flash_oe_n;
    half_word_t  flash_data_out;
    logic        flash_data_oe;
    half_word_t  flash_data_in;

    // expected buffer state, whole address kept as tag.
    logic       line_valid [LINES];
    word_addr_t line_addr  [LINES];

    flash_read_top #(.WAIT_CYCLES(WAIT_CYCLES), .LINES(LINES)) dut0 (.*);

    flash_model model0 (
        .clk       (clk),
        .rst       (rst),
        .address   (flash_address),
        .ce_n      (flash_ce_n),
        .we_n      (flash_we_n),
        .oe_n      (flash_oe_n),
        .cmd_data  (flash_data_out),
        .cmd_oe    (flash_data_oe),
        .read_data (flash_data_in)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            fail_now($sformatf("mismatch at %0t: %s is %h, expected %h",
                               $time, what, actual, expected));
        end
    endtask

    task automatic check_count(input int actual, input int expected, input string what);
        if (actual != expected) begin
            fail_now($sformatf("mismatch at %0t: %s is %0d, expected %0d",
                               $time, what, actual, expected));
        end
    endtask

    task automatic check_level(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            fail_now($sformatf("mismatch at %0t: %s is %b, expected %b",
                               $time, what, actual, expected));
        end
    endtask

    // word a is array entries 2a+1 and 2a.
    function automatic word_t expected_word(input word_addr_t addr);
        int base;
        base = 2 * int'(addr);
        return {model0.mem[base + 1], model0.mem[base]};
    endfunction

    function automatic logic predict_miss(input word_addr_t addr);
        int line;
        line = int'(addr) % LINES;
        return !(line_valid[line] && line_addr[line] == addr);
    endfunction

    // outputs sampled a quarter period after the falling edge.
    task automatic read_word(input word_addr_t addr, output word_t data, output int stalls,
                             output logic touched);
        logic done;
        done = 1'b0;
        stalls = 0;
        touched = 1'b0;
        data = '0;
        @(negedge clk);
        bus_address = addr;
        bus_read = 1'b1;
        while (!done) begin
            #(CLK_PERIOD / 4);
            touched = touched || !flash_ce_n;
            if (!bus_stall) begin
                data = bus_read_data;
                done = 1'b1;
            end else if (stalls == TIMEOUT) begin
                fail_now($sformatf("read of word %0h not finished in %0d cycles", addr, TIMEOUT));
            end else begin
                stalls++;
                @(negedge clk);
            end
        end
        @(negedge clk);
        // a flash access started by the completing cycle shows up here.
        touched = touched || !flash_ce_n;
        bus_read = 1'b0;
    endtask

    task automatic expect_read(input word_addr_t addr, input logic miss);
        word_t data;
        int    stalls;
        logic  touched;
        int    line;
        read_word(addr, data, stalls, touched);
        check_word(data, expected_word(addr), $sformatf("data of word %0h", addr));
        check_count(stalls, miss ? MISS_STALLS : 0, $sformatf("stall cycles of word %0h", addr));
        check_level(touched, miss, $sformatf("flash access for word %0h", addr));
        line = int'(addr) % LINES;
        line_valid[line] = 1'b1;
        line_addr[line] = addr;
    endtask

    task automatic after_reset_idle();
        @(negedge clk);
        #(CLK_PERIOD / 4);
        check_level(flash_ce_n, 1'b1, "ce_n after reset");
        check_level(flash_we_n, 1'b1, "we_n after reset");
        check_level(flash_oe_n, 1'b1, "oe_n after reset");
        check_level(flash_data_oe, 1'b0, "flash_data_oe after reset");
        check_level(bus_stall, 1'b0, "bus_stall while idle");
    endtask

    task automatic first_read_miss();
        expect_read(word_addr_t'(FIRST_ADDR), 1'b1);
    endtask

    task automatic repeat_read_hit();
        expect_read(word_addr_t'(FIRST_ADDR), 1'b0);
    endtask

    // same line, so the middle read evicts the first.
    task automatic conflict_eviction();
        expect_read(word_addr_t'(CONFLICT_ADDR), 1'b1);
        expect_read(word_addr_t'(CONFLICT_ADDR + LINES), 1'b1);
        expect_read(word_addr_t'(CONFLICT_ADDR), 1'b1);
    endtask

    task automatic random_read_sweep();
        word_addr_t addr;
        logic       miss;
        for (int i = 0; i < RANDOM_READS; i++) begin
            addr = word_addr_t'($urandom_range(RANDOM_SPAN - 1, 0));
            miss = predict_miss(addr);
            expect_read(addr, miss);
        end
    endtask

    initial begin
        rst = 1'b1;
        bus_address = '0;
        bus_read = 1'b0;
        for (int i = 0; i < LINES; i++) begin
            line_valid[i] = 1'b0;
            line_addr[i] = '0;
        end
        void'($urandom(RANDOM_SEED));
        model0.fill_random();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        after_reset_idle();
        first_read_miss();
        repeat_read_hit();
        conflict_eviction();
        random_read_sweep();
        $display("All tests passed!");
        $finish;
    end

endmodule

/* bench/flash_pins_chk.sv */
`timescale 1ns/1ps

module flash_pins_chk (
    input logic clk,
    input logic rst,
    input logic ce_n,
    input logic we_n,
    input logic oe_n,
    input logic data_oe
);

    // no bus fight with the flash outputs.
    no_data_contention: assert property (@(posedge clk) disable iff (rst)
        !(!oe_n && data_oe))
        else $error("flash data bus driven while oe_n is low");

    we_needs_ce: assert property (@(posedge clk) disable iff (rst)
        !we_n |-> !ce_n)
        else $error("we_n low while the flash is not selected");

    data_oe_matches_we: assert property (@(posedge clk) disable iff (rst)
        !ce_n |-> (data_oe == !we_n))
        else $error("data bus enable does not follow we_n");

endmodule

bind flash_controller flash_pins_chk pins_chk0 (
    .clk     (clk),
    .rst     (rst),
    .ce_n    (flash_ce_n),
    .we_n    (flash_we_n),
    .oe_n    (flash_oe_n),
    .data_oe (flash_data_oe)
);

/* bench/flash_model.sv */
`timescale 1ns/1ps

module flash_model
    import flash_pkg::*;
#(
    parameter int DEPTH = 64
) (
    input  logic        clk,
    input  logic        rst,
    input  flash_addr_t address,
    input  logic        ce_n,
    input  logic        we_n,
    input  logic        oe_n,
    input  half_word_t  cmd_data,
    input  logic        cmd_oe,
    output half_word_t  read_data
);

    localparam int INDEX_BITS = $clog2(DEPTH);

    half_word_t            mem [DEPTH];
    logic [INDEX_BITS-1:0] index;
    logic                  read_mode;

    // half-word entry, byte bit dropped.
    assign index = address[INDEX_BITS:1];

    task automatic fill_random();
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = half_word_t'($urandom);
        end
    endtask

    // last command written picks the mode.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_mode <= 1'b0;
        end else if (!ce_n && !we_n) begin
            read_mode <= cmd_oe && (cmd_data == FLASH_CMD_READ_ARRAY);
        end
    end

    // status byte unless in read-array mode.
    assign read_data = (!ce_n && !oe_n && read_mode) ? mem[index] : 16'h0080;

endmodule

/* verilog/flash_read_top.sv */
`timescale 1ns/1ps

module flash_read_top
    import flash_pkg::*;
#(
    parameter int WAIT_CYCLES = 3,
    parameter int LINES       = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  word_addr_t  bus_address,
    input  logic        bus_read,
    output word_t       bus_read_data,
    output logic        bus_stall,
    output flash_addr_t flash_address,
    output logic        flash_ce_n,
    output logic        flash_we_n,
    output logic        flash_oe_n,
    output half_word_t  flash_data_out,
    output logic        flash_data_oe,
    input  half_word_t  flash_data_in
);

    // buffer to controller request path.
    flash_bus_if mem_bus ();

    flash_read_buffer #(
        .LINES(LINES)
    ) buffer0 (
        .clk           (clk),
        .rst           (rst),
        .cpu_address   (bus_address),
        .cpu_read      (bus_read),
        .cpu_read_data (bus_read_data),
        .cpu_stall     (bus_stall),
        .mem           (mem_bus)
    );

    flash_controller #(
        .WAIT_CYCLES(WAIT_CYCLES)
    ) controller0 (
        .clk            (clk),
        .rst            (rst),
        .bus            (mem_bus),
        .flash_address  (flash_address),
        .flash_ce_n     (flash_ce_n),
        .flash_we_n     (flash_we_n),
        .flash_oe_n     (flash_oe_n),
        .flash_data_out (flash_data_out),
        .flash_data_oe  (flash_data_oe),
        .flash_data_in  (flash_data_in)
    );

endmodule

/* verilog/flash_read_buffer.sv */
`timescale 1ns/1ps

module flash_read_buffer
    import flash_pkg::*;
#(
    parameter int LINES = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  word_addr_t cpu_address,
    input  logic       cpu_read,
    output word_t      cpu_read_data,
    output logic       cpu_stall,
    flash_bus_if.requester mem
);

    localparam int INDEX_BITS = $clog2(LINES);
    localparam int TAG_BITS   = WORD_ADDR_BITS - INDEX_BITS;

    logic [LINES-1:0]    valid;
    logic [TAG_BITS-1:0] tags  [LINES];
    word_t               words [LINES];

    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;
    logic                  hit;
    logic                  fill;

    // low address bits pick the line.
    assign index = cpu_address[INDEX_BITS-1:0];
    assign tag   = cpu_address[WORD_ADDR_BITS-1:INDEX_BITS];

    assign hit = cpu_read && valid[index] && (tags[index] == tag);

    // misses pass straight through to the controller.
    assign mem.address = cpu_address;
    assign mem.read    = cpu_read && !hit;

    assign cpu_read_data = hit ? words[index] : mem.read_data;
    assign cpu_stall     = !hit && mem.stall;

    // fill when the forwarded read completes.
    assign fill = mem.read && !mem.stall;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (fill) begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[index]  <= tag;
            words[index] <= mem.read_data;
        end
    end

endmodule

/* verilog/flash_controller.sv */
`timescale 1ns/1ps

module flash_controller
    import flash_pkg::*;
#(
    parameter int WAIT_CYCLES = 3
) (
    input  logic        clk,
    input  logic        rst,
    flash_bus_if.responder bus,
    output flash_addr_t flash_address,
    output logic        flash_ce_n,
    output logic        flash_we_n,
    output logic        flash_oe_n,
    output half_word_t  flash_data_out,
    output logic        flash_data_oe,
    input  half_word_t  flash_data_in
);

    localparam int CNT_BITS = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CMD,
        ST_READ,
        ST_DONE
    } state_t;

    state_t              state;
    logic                half;
    logic [CNT_BITS-1:0] cnt;
    logic                last;
    logic                accept;

    word_addr_t addr_q;
    half_word_t low_q;
    half_word_t high_q;

    assign last   = (cnt == CNT_BITS'(WAIT_CYCLES - 1));
    assign accept = (state == ST_IDLE) && bus.read;

    // two phases per half, low half first.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            half  <= 1'b0;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (bus.read) begin
                        state <= ST_CMD;
                        half  <= 1'b0;
                        cnt   <= '0;
                    end
                end
                ST_CMD: begin
                    if (last) begin
                        state <= ST_READ;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_READ: begin
                    if (last) begin
                        cnt <= '0;
                        if (half) begin
                            state <= ST_DONE;
                        end else begin
                            half  <= 1'b1;
                            state <= ST_CMD;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // address held for the whole access.
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= bus.address;
        end
    end

    // sample in the last read cycle of each half.
    always_ff @(posedge clk) begin
        if (state == ST_READ && last) begin
            if (half) begin
                high_q <= flash_data_in;
            end else begin
                low_q <= flash_data_in;
            end
        end
    end

    assign flash_address = {addr_q, half, 1'b0};

    assign flash_ce_n    = !(state == ST_CMD || state == ST_READ);
    assign flash_we_n    = (state != ST_CMD);
    assign flash_oe_n    = (state != ST_READ);
    assign flash_data_oe = (state == ST_CMD);

    assign flash_data_out = flash_data_oe ? FLASH_CMD_READ_ARRAY : '0;

    assign bus.read_data = {high_q, low_q};

    // stall from the pending request while idle, low only when done.
    always_comb begin
        case (state)
            ST_IDLE: bus.stall = bus.read;
            ST_DONE: bus.stall = 1'b0;
            default: bus.stall = 1'b1;
        endcase
    end

endmodule

/* verilog/flash_bus_if.sv */
`timescale 1ns/1ps

interface flash_bus_if
    import flash_pkg::*;
();

    word_addr_t address;
    logic       read;
    word_t      read_data;
    logic       stall;

    // the read buffer side.
    modport requester (
        output address,
        output read,
        input  read_data,
        input  stall
    );

    // the flash controller side.
    modport responder (
        input  address,
        input  read,
        output read_data,
        output stall
    );

endinterface

/* verilog/flash_pkg.sv */
package flash_pkg;

    // cpu word address width, 8 MB of flash.
    localparam int WORD_ADDR_BITS = 21;

    // flash byte address adds half-word select and byte bit.
    localparam int FLASH_ADDR_BITS = WORD_ADDR_BITS + 2;

    // cpu data word.
    typedef logic [31:0] word_t;

    // flash data bus value.
    typedef logic [15:0] half_word_t;

    // cpu word address.
    typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;

    // flash byte address.
    typedef logic [FLASH_ADDR_BITS-1:0] flash_addr_t;

    // read-array command, written before every half-word read.
    localparam half_word_t FLASH_CMD_READ_ARRAY = 16'h00ff;

endpackage
